//--- Makefile
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module tb_dmni -Mdir obj_dir -f project.f
	./obj_dir/Vtb_dmni | tee $(LOG)
	! grep -q "STATUS: FAIL" $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --top-module dmni \
		design/dmni_pkg.sv design/mem_port_if.sv design/hermes_receive.sv \
		design/hermes_send.sv design/mem_arbiter.sv design/dmni.sv

clean:
	rm -rf obj_dir $(LOG)

//--- design/dmni.sv
`timescale 1ns/10ps

module dmni
    import dmni_pkg::*;
#(
    parameter int unsigned ARB_SLICE = 15
)
(
    input  logic     clk_i,
    input  logic     rst_ni,

    // network receive
    input  logic     noc_rx_i,
    output logic     noc_credit_o,
    input  flit_t    noc_data_i,

    // network send
    output logic     noc_tx_o,
    input  logic     noc_ack_i,
    output flit_t    noc_data_o,

    // memory
    output byte_en_t mem_we_o,
    output addr_t    mem_addr_o,
    output flit_t    mem_data_o,
    input  flit_t    mem_data_i,

    // configuration
    input  logic     cfg_start_i,
    input  logic     cfg_operation_i,
    input  addr_t    cfg_address_i,
    input  addr_t    cfg_address_2_i,
    input  count_t   cfg_size_i,
    input  count_t   cfg_size_2_i,

    // status
    output logic     send_active_o,
    output logic     receive_active_o,
    output logic     receive_available_o,
    output count_t   receive_flits_available_o
);

    logic send_start;
    logic recv_start;

    assign send_start = cfg_start_i && (cfg_operation_i == OP_SEND);
    assign recv_start = cfg_start_i && (cfg_operation_i == OP_RECEIVE);

    mem_port_if send_port ();
    mem_port_if recv_port ();

    hermes_receive u_receive (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .noc_rx_i          (noc_rx_i),
        .noc_credit_o      (noc_credit_o),
        .noc_data_i        (noc_data_i),
        .start_i           (recv_start),
        .address_i         (cfg_address_i),
        .size_i            (cfg_size_i),
        .active_o          (receive_active_o),
        .available_o       (receive_available_o),
        .flits_available_o (receive_flits_available_o),
        .mem               (recv_port)
    );

    hermes_send u_send (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .noc_tx_o    (noc_tx_o),
        .noc_ack_i   (noc_ack_i),
        .noc_data_o  (noc_data_o),
        .start_i     (send_start),
        .address_i   (cfg_address_i),
        .address_2_i (cfg_address_2_i),
        .size_i      (cfg_size_i),
        .size_2_i    (cfg_size_2_i),
        .active_o    (send_active_o),
        .mem         (send_port)
    );

    mem_arbiter #(
        .ARB_SLICE (ARB_SLICE)
    ) u_arbiter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .send_port  (send_port),
        .recv_port  (recv_port),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_data_o),
        .mem_data_i (mem_data_i)
    );

endmodule

//--- design/dmni_pkg.sv
package dmni_pkg;

    // one network flit is also one memory word
    typedef logic [31:0] flit_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] count_t;
    typedef logic [3:0]  byte_en_t;

    // byte address step between consecutive words
    localparam int unsigned WORD_BYTES = 4;

    // values of the operation bit sampled with the start strobe
    localparam logic OP_SEND    = 1'b0;
    localparam logic OP_RECEIVE = 1'b1;

    typedef enum logic [1:0] {
        RECV_HEADER,
        RECV_SIZE,
        RECV_WAIT,
        RECV_DATA
    } recv_state_t;

    typedef enum logic {
        SEND_IDLE,
        SEND_DATA
    } send_state_t;

endpackage

//--- design/hermes_receive.sv
`timescale 1ns/10ps

module hermes_receive
    import dmni_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,

    // network side
    input  logic   noc_rx_i,
    output logic   noc_credit_o,
    input  flit_t  noc_data_i,

    // receive command
    input  logic   start_i,
    input  addr_t  address_i,
    input  count_t size_i,

    // status
    output logic   active_o,
    output logic   available_o,
    output count_t flits_available_o,

    mem_port_if.requester mem
);

    recv_state_t state_q;
    recv_state_t state_d;

    count_t payload_cnt_q;
    count_t cmd_cnt_q;
    addr_t  wr_addr_q;

    logic accept;

    // a flit only moves in data when the memory port is ours
    always_comb begin
        case (state_q)
            RECV_WAIT: noc_credit_o = 1'b0;
            RECV_DATA: noc_credit_o = mem.gnt;
            default:   noc_credit_o = 1'b1;
        endcase
    end

    assign accept = noc_rx_i && noc_credit_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            RECV_HEADER: begin
                if (accept)
                    state_d = RECV_SIZE;
            end
            RECV_SIZE: begin
                if (accept)
                    state_d = RECV_WAIT;
            end
            RECV_WAIT: begin
                if (start_i)
                    state_d = RECV_DATA;
            end
            RECV_DATA: begin
                // end of packet wins over end of command
                if (accept) begin
                    if (payload_cnt_q == count_t'(1))
                        state_d = RECV_HEADER;
                    else if (cmd_cnt_q == count_t'(1))
                        state_d = RECV_WAIT;
                end
            end
            default: state_d = RECV_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= RECV_HEADER;
            payload_cnt_q <= '0;
            cmd_cnt_q     <= '0;
            wr_addr_q     <= '0;
        end
        else begin
            state_q <= state_d;
            if (state_q == RECV_SIZE && accept)
                payload_cnt_q <= noc_data_i;
            else if (state_q == RECV_WAIT && start_i) begin
                wr_addr_q <= address_i;
                cmd_cnt_q <= size_i;
            end
            else if (state_q == RECV_DATA && accept) begin
                wr_addr_q     <= wr_addr_q + WORD_BYTES;
                cmd_cnt_q     <= cmd_cnt_q - 1'b1;
                payload_cnt_q <= payload_cnt_q - 1'b1;
            end
        end
    end

    // write straight from the network, full word only
    assign mem.req   = (state_q == RECV_DATA);
    assign mem.we    = noc_rx_i ? '1 : '0;
    assign mem.addr  = wr_addr_q;
    assign mem.wdata = noc_data_i;

    assign active_o          = (state_q == RECV_DATA);
    assign available_o       = (state_q == RECV_WAIT);
    assign flits_available_o = payload_cnt_q;

endmodule

//--- design/hermes_send.sv
`timescale 1ns/10ps

module hermes_send
    import dmni_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,

    // network side
    output logic   noc_tx_o,
    input  logic   noc_ack_i,
    output flit_t  noc_data_o,

    // send command, two segments
    input  logic   start_i,
    input  addr_t  address_i,
    input  addr_t  address_2_i,
    input  count_t size_i,
    input  count_t size_2_i,

    output logic   active_o,

    mem_port_if.requester mem
);

    send_state_t state_q;
    send_state_t state_d;

    addr_t  addr_1_q;
    addr_t  addr_2_q;
    count_t size_1_q;
    count_t size_2_q;

    logic seg_1;
    logic sent;
    logic last_word;

    // first segment until it runs dry
    assign seg_1 = (size_1_q != '0);
    assign sent  = noc_tx_o && noc_ack_i;

    assign last_word = (size_1_q == count_t'(1) && size_2_q == '0)
        || (size_1_q == '0 && size_2_q == count_t'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEND_IDLE: begin
                if (start_i)
                    state_d = SEND_DATA;
            end
            SEND_DATA: begin
                if (sent && last_word)
                    state_d = SEND_IDLE;
            end
            default: state_d = SEND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= SEND_IDLE;
            addr_1_q <= '0;
            addr_2_q <= '0;
            size_1_q <= '0;
            size_2_q <= '0;
        end
        else begin
            state_q <= state_d;
            if (state_q == SEND_IDLE && start_i) begin
                addr_1_q <= address_i;
                addr_2_q <= address_2_i;
                size_1_q <= size_i;
                size_2_q <= size_2_i;
            end
            else if (sent) begin
                if (seg_1) begin
                    addr_1_q <= addr_1_q + WORD_BYTES;
                    size_1_q <= size_1_q - 1'b1;
                end
                else begin
                    addr_2_q <= addr_2_q + WORD_BYTES;
                    size_2_q <= size_2_q - 1'b1;
                end
            end
        end
    end

    // read only port, data goes out the same cycle
    assign mem.req   = (state_q == SEND_DATA);
    assign mem.we    = '0;
    assign mem.addr  = seg_1 ? addr_1_q : addr_2_q;
    assign mem.wdata = '0;

    assign noc_tx_o   = (state_q == SEND_DATA) && mem.gnt;
    assign noc_data_o = mem.rdata;
    assign active_o   = (state_q == SEND_DATA);

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter
    import dmni_pkg::*;
#(
    parameter int unsigned ARB_SLICE = 15
)
(
    input  logic     clk_i,
    input  logic     rst_ni,

    mem_port_if.arbiter send_port,
    mem_port_if.arbiter recv_port,

    // shared memory port
    output byte_en_t mem_we_o,
    output addr_t    mem_addr_o,
    output flit_t    mem_data_o,
    input  flit_t    mem_data_i
);

    localparam int unsigned TIMER_W = $clog2(ARB_SLICE + 1);

    // low means send holds the port
    logic               grant_recv_q;
    logic               grant_recv_d;
    logic [TIMER_W-1:0] timer_q;

    logic any_req;
    logic holder_req;
    logic rearbitrate;

    assign any_req    = send_port.req || recv_port.req;
    assign holder_req = grant_recv_q ? recv_port.req : send_port.req;

    // slice expired or holder went idle
    assign rearbitrate = any_req && (timer_q == '0 || !holder_req);

    // hand over only if the other side is asking
    always_comb begin
        if (grant_recv_q)
            grant_recv_d = !send_port.req;
        else
            grant_recv_d = recv_port.req;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            grant_recv_q <= 1'b0;
            timer_q      <= '0;
        end
        else if (rearbitrate) begin
            grant_recv_q <= grant_recv_d;
            timer_q      <= TIMER_W'(ARB_SLICE);
        end
        else if (timer_q != '0) begin
            timer_q <= timer_q - 1'b1;
        end
    end

    assign send_port.gnt = !grant_recv_q && send_port.req;
    assign recv_port.gnt = grant_recv_q && recv_port.req;

    assign mem_addr_o = grant_recv_q ? recv_port.addr  : send_port.addr;
    assign mem_data_o = grant_recv_q ? recv_port.wdata : send_port.wdata;

    always_comb begin
        if (recv_port.gnt)
            mem_we_o = recv_port.we;
        else if (send_port.gnt)
            mem_we_o = send_port.we;
        else
            mem_we_o = '0;
    end

    // reads are combinational, both sides see the same word
    assign send_port.rdata = mem_data_i;
    assign recv_port.rdata = mem_data_i;

endmodule

//--- design/mem_port_if.sv
`timescale 1ns/10ps

interface mem_port_if
    import dmni_pkg::*;
();

    logic     req;
    logic     gnt;
    byte_en_t we;
    addr_t    addr;
    flit_t    wdata;
    flit_t    rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    // mirror of the requester side
    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

//--- project.f
design/dmni_pkg.sv
design/mem_port_if.sv
design/hermes_receive.sv
design/hermes_send.sv
design/mem_arbiter.sv
design/dmni.sv
test/tb_dmni.sv

//--- test/tb_dmni.sv
`timescale 1ns/10ps

module tb_dmni
    import dmni_pkg::*;
();

    localparam int unsigned MEM_WORDS = 1024;
    localparam logic [31:0] SEED      = 32'h68a8;

    localparam int unsigned T2_LEN  = 6;
    localparam int unsigned T3_LEN  = 8;
    localparam int unsigned T3_CMD  = 3;
    localparam int unsigned T4_LEN1 = 5;
    localparam int unsigned T4_LEN2 = 4;
    localparam int unsigned T4_LEN3 = 3;
    localparam int unsigned T5_RECV = 12;
    localparam int unsigned T5_LEN1 = 7;
    localparam int unsigned T5_LEN2 = 6;

    // received packets carry a header and a size flit on top of the payload
    localparam int unsigned TOTAL_FLITS = (T2_LEN + 2) + (T3_LEN + 2) + T4_LEN1 + T4_LEN2
        + T4_LEN3 + (T5_RECV + 2) + T5_LEN1 + T5_LEN2;
    localparam int unsigned WATCHDOG_CYCLES = TOTAL_FLITS * 40 + 2000;

    logic     clk_i = 1'b0;
    logic     rst_ni;
    logic     noc_rx_i = 1'b0;
    logic     noc_credit_o;
    flit_t    noc_data_i = '0;
    logic     noc_tx_o;
    logic     noc_ack_i = 1'b0;
    flit_t    noc_data_o;
    byte_en_t mem_we_o;
    addr_t    mem_addr_o;
    flit_t    mem_data_o;
    flit_t    mem_data_i;
    logic     cfg_start_i;
    logic     cfg_operation_i;
    addr_t    cfg_address_i;
    addr_t    cfg_address_2_i;
    count_t   cfg_size_i;
    count_t   cfg_size_2_i;
    logic     send_active_o;
    logic     receive_active_o;
    logic     receive_available_o;
    count_t   receive_flits_available_o;

    flit_t       mem [MEM_WORDS];
    flit_t       src_q [$];
    flit_t       payload_q [$];
    flit_t       exp_send [$];
    int          src_pos = 0;
    int          send_seen = 0;
    logic [31:0] net_rng = SEED;
    logic [31:0] stim_rng = SEED;
    logic        we_forbidden = 1'b0;
    string       test_name = "startup";
    int          check_errors = 0;
    int          net_errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #50 clk_i = ~clk_i;

    dmni #(
        .ARB_SLICE (15)
    ) UUT (
        .clk_i                     (clk_i),
        .rst_ni                    (rst_ni),
        .noc_rx_i                  (noc_rx_i),
        .noc_credit_o              (noc_credit_o),
        .noc_data_i                (noc_data_i),
        .noc_tx_o                  (noc_tx_o),
        .noc_ack_i                 (noc_ack_i),
        .noc_data_o                (noc_data_o),
        .mem_we_o                  (mem_we_o),
        .mem_addr_o                (mem_addr_o),
        .mem_data_o                (mem_data_o),
        .mem_data_i                (mem_data_i),
        .cfg_start_i               (cfg_start_i),
        .cfg_operation_i           (cfg_operation_i),
        .cfg_address_i             (cfg_address_i),
        .cfg_address_2_i           (cfg_address_2_i),
        .cfg_size_i                (cfg_size_i),
        .cfg_size_2_i              (cfg_size_2_i),
        .send_active_o             (send_active_o),
        .receive_active_o          (receive_active_o),
        .receive_available_o       (receive_available_o),
        .receive_flits_available_o (receive_flits_available_o)
    );

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // preload value of every word from its byte address
    function automatic flit_t pattern_word(addr_t addr);
        return xorshift(addr ^ SEED);
    endfunction

    // k-th word of a two segment send
    function automatic flit_t expected_send_word(addr_t a1, count_t n1, addr_t a2,
                                                 int unsigned k);
        if (k < n1)
            return pattern_word(a1 + WORD_BYTES * k);
        return pattern_word(a2 + WORD_BYTES * (k - n1));
    endfunction

    // memory with combinational read that is reloaded while in reset
    assign mem_data_i = mem[mem_addr_o[11:2]];

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= pattern_word(i * WORD_BYTES);
        end
        else if (mem_we_o != '0) begin
            mem[mem_addr_o[11:2]] <= mem_data_o;
        end
    end

    // network source and sink with the sent stream compare and the write watch
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            noc_rx_i  <= 1'b0;
            noc_ack_i <= 1'b0;
        end
        else begin
            net_rng = xorshift(net_rng);
            if (noc_rx_i && noc_credit_o)
                src_pos = src_pos + 1;
            if (noc_tx_o && noc_ack_i) begin
                assert (send_seen < exp_send.size()) else begin
                    $display("ERROR %s: a flit left beyond the expected stream", test_name);
                    net_errors++;
                end
                if (send_seen < exp_send.size()) begin
                    assert (noc_data_o == exp_send[send_seen]) else begin
                        $display("FAIL %s sent flit %0d: expected %h, actual %h", test_name,
                                 send_seen, exp_send[send_seen], noc_data_o);
                        net_errors++;
                    end
                end
                send_seen = send_seen + 1;
            end
            assert (!we_forbidden || mem_we_o == '0) else begin
                $display("FAIL %s mem_we_o: expected %h, actual %h", test_name, 4'h0, mem_we_o);
                net_errors++;
            end
            // every write is a full word
            assert (mem_we_o == '0 || mem_we_o == 4'hF) else begin
                $display("FAIL %s mem_we_o: expected %h, actual %h", test_name, 4'hF,
                         mem_we_o);
                net_errors++;
            end
            if (src_pos < src_q.size() && net_rng[1:0] != 2'b00) begin
                noc_rx_i   <= 1'b1;
                noc_data_i <= src_q[src_pos];
            end
            else begin
                noc_rx_i <= 1'b0;
            end
            noc_ack_i <= (net_rng[9:8] != 2'b00);
        end
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            check_errors++;
        end
    endtask

    task automatic begin_test(string name);
        test_name = name;
        errors_at_start = check_errors + net_errors;
    endtask

    task automatic end_test();
        int failed_checks;
        failed_checks = check_errors + net_errors - errors_at_start;
        tests_run++;
        if (failed_checks == 0) begin
            $display("test %s: ok", test_name);
        end
        else begin
            $display("test %s: %0d errors", test_name, failed_checks);
            tests_failed++;
        end
    endtask

    task automatic issue_command(logic op, addr_t a1, count_t n1, addr_t a2, count_t n2);
        @(posedge clk_i);
        cfg_start_i     <= 1'b1;
        cfg_operation_i <= op;
        cfg_address_i   <= a1;
        cfg_size_i      <= n1;
        cfg_address_2_i <= a2;
        cfg_size_2_i    <= n2;
        @(posedge clk_i);
        cfg_start_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic queue_packet(int unsigned len);
        payload_q.delete();
        src_q.push_back(32'h0000_0102);
        src_q.push_back(len);
        for (int unsigned k = 0; k < len; k++) begin
            stim_rng = xorshift(stim_rng);
            payload_q.push_back(stim_rng);
            src_q.push_back(stim_rng);
        end
    endtask

    task automatic check_memory(addr_t addr, int unsigned first, int unsigned count);
        addr_t a;
        for (int unsigned k = 0; k < count; k++) begin
            a = addr + WORD_BYTES * k;
            check_value($sformatf("word at %h", a), payload_q[first + k], mem[a[11:2]]);
        end
        // nothing may spill past the command
        a = addr + WORD_BYTES * count;
        check_value("word after the written range", pattern_word(a), mem[a[11:2]]);
    endtask

    task automatic expect_send_stream(addr_t a1, count_t n1, addr_t a2, count_t n2);
        for (int unsigned k = 0; k < n1 + n2; k++)
            exp_send.push_back(expected_send_word(a1, n1, a2, k));
    endtask

    task automatic send_and_wait(addr_t a1, count_t n1, addr_t a2, count_t n2);
        expect_send_stream(a1, n1, a2, n2);
        issue_command(OP_SEND, a1, n1, a2, n2);
        while (send_active_o)
            @(negedge clk_i);
        check_value("sent flit count", exp_send.size(), send_seen);
    endtask

    initial begin
        rst_ni          = 1'b0;
        cfg_start_i     = 1'b0;
        cfg_operation_i = OP_SEND;
        cfg_address_i   = '0;
        cfg_address_2_i = '0;
        cfg_size_i      = '0;
        cfg_size_2_i    = '0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);

        begin_test("reset");
        check_value("noc_tx_o", 0, noc_tx_o);
        check_value("noc_credit_o", 1, noc_credit_o);
        check_value("mem_we_o", 0, mem_we_o);
        check_value("send_active_o", 0, send_active_o);
        check_value("receive_active_o", 0, receive_active_o);
        end_test();

        begin_test("single receive");
        queue_packet(T2_LEN);
        while (!receive_available_o)
            @(negedge clk_i);
        check_value("flits available", T2_LEN, receive_flits_available_o);
        issue_command(OP_RECEIVE, 32'h100, T2_LEN, '0, '0);
        while (receive_active_o)
            @(negedge clk_i);
        check_memory(32'h100, 0, T2_LEN);
        check_value("flits available after drain", 0, receive_flits_available_o);
        end_test();

        begin_test("split receive");
        queue_packet(T3_LEN);
        while (!receive_available_o)
            @(negedge clk_i);
        check_value("flits available", T3_LEN, receive_flits_available_o);
        issue_command(OP_RECEIVE, 32'h200, T3_CMD, '0, '0);
        while (!receive_available_o)
            @(negedge clk_i);
        check_value("flits left", T3_LEN - T3_CMD, receive_flits_available_o);
        check_value("receive_active_o", 0, receive_active_o);
        check_memory(32'h200, 0, T3_CMD);
        issue_command(OP_RECEIVE, 32'h300, T3_LEN - T3_CMD, '0, '0);
        while (receive_active_o)
            @(negedge clk_i);
        check_memory(32'h300, T3_CMD, T3_LEN - T3_CMD);
        check_value("credit for a new header", 1, noc_credit_o);
        check_value("receive_available_o", 0, receive_available_o);
        end_test();

        begin_test("two segment send");
        we_forbidden = 1'b1;
        send_and_wait(32'h400, T4_LEN1, 32'h600, T4_LEN2);
        send_and_wait(32'h700, T4_LEN3, 32'h800, 0);
        we_forbidden = 1'b0;
        end_test();

        begin_test("concurrent send and receive");
        queue_packet(T5_RECV);
        while (!receive_available_o)
            @(negedge clk_i);
        check_value("flits available", T5_RECV, receive_flits_available_o);
        expect_send_stream(32'hA00, T5_LEN1, 32'hB00, T5_LEN2);
        issue_command(OP_RECEIVE, 32'h900, T5_RECV, '0, '0);
        issue_command(OP_SEND, 32'hA00, T5_LEN1, 32'hB00, T5_LEN2);
        while (receive_active_o || send_active_o)
            @(negedge clk_i);
        check_memory(32'h900, 0, T5_RECV);
        check_value("sent flit count", exp_send.size(), send_seen);
        check_value("flits available after drain", 0, receive_flits_available_o);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 check_errors + net_errors);
        if (check_errors + net_errors == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("ERROR %s: watchdog expired after %0d cycles", test_name, WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
